// File: verilog/sqrt_pkg.sv
package sqrt_pkg;

    // fixed-point format, unsigned Q8.8
    localparam int DATA_W = 16;
    localparam int FRAC_W = 8;
    localparam int ITERS  = (DATA_W + FRAC_W) / 2;  // one root bit per step

    // engine internals
    localparam int RAD_W      = DATA_W + FRAC_W;  // operand after pre-shift
    localparam int ACC_W      = RAD_W + 2;
    localparam int ITER_CNT_W = $clog2(ITERS);

    // bus widths
    localparam int AXI_ADDR_W = 5;
    localparam int AXI_DATA_W = 32;

    typedef logic [DATA_W-1:0]     operand_t;
    typedef logic [DATA_W-1:0]     root_t;      // upper bits stay zero
    typedef logic [DATA_W-1:0]     rem_t;
    typedef logic [ITER_CNT_W-1:0] iter_cnt_t;
    typedef logic [AXI_ADDR_W-1:0] axil_addr_t;
    typedef logic [AXI_DATA_W-1:0] axil_data_t;
    typedef logic [1:0]            axil_resp_t;

    localparam iter_cnt_t ITER_LAST = iter_cnt_t'(ITERS - 1);

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    // register map, byte offsets
    localparam axil_addr_t REG_CTRL    = 5'h00;  // write only
    localparam axil_addr_t REG_OPER0   = 5'h04;
    localparam axil_addr_t REG_OPER1   = 5'h08;
    localparam axil_addr_t REG_STATUS  = 5'h0C;  // read only
    localparam axil_addr_t REG_RESULT0 = 5'h10;  // read only
    localparam axil_addr_t REG_RESULT1 = 5'h14;  // read only

endpackage

// File: verilog/sqrt_chan_if.sv
`timescale 1ns/100ps

interface sqrt_chan_if;

    logic               start;      // one-cycle pulse
    sqrt_pkg::operand_t operand;
    logic               busy;
    logic               done;       // one-cycle pulse, results valid
    sqrt_pkg::root_t    root;
    sqrt_pkg::rem_t     remainder;

    modport host (
        output start,
        output operand
    );

    modport engine (
        input  start,
        input  operand,
        output busy,
        output done,
        output root,
        output remainder
    );

    modport collect (
        input start,
        input busy,
        input done,
        input root,
        input remainder
    );

endinterface

// File: verilog/axil_sqrt_regs.sv
`timescale 1ns/100ps

module axil_sqrt_regs (
    input  logic                   clk,
    input  logic                   rst_n,

    input  sqrt_pkg::axil_addr_t   awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  sqrt_pkg::axil_data_t   wdata,
    input  logic                   wvalid,
    output logic                   wready,
    output sqrt_pkg::axil_resp_t   bresp,
    output logic                   bvalid,
    input  logic                   bready,

    input  sqrt_pkg::axil_addr_t   araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output sqrt_pkg::axil_data_t   rdata,
    output sqrt_pkg::axil_resp_t   rresp,
    output logic                   rvalid,
    input  logic                   rready,

    input  sqrt_pkg::axil_data_t   status,
    input  sqrt_pkg::axil_data_t   result0,
    input  sqrt_pkg::axil_data_t   result1,

    sqrt_chan_if.host              ch0,
    sqrt_chan_if.host              ch1
);

    logic                 wr_hs;
    logic                 rd_hs;
    logic                 wr_ok;
    logic                 aw_take;
    sqrt_pkg::axil_data_t rd_data;
    sqrt_pkg::axil_resp_t rd_resp;
    sqrt_pkg::operand_t   oper0;
    sqrt_pkg::operand_t   oper1;
    logic                 start0;
    logic                 start1;

    assign wr_hs = awvalid && awready && wvalid && wready;
    assign rd_hs = arvalid && arready;

    // address and data must both be present, one at a time
    assign aw_take = awvalid && wvalid && !awready && !bvalid;

    always_comb begin
        case (awaddr)
            sqrt_pkg::REG_CTRL,
            sqrt_pkg::REG_OPER0,
            sqrt_pkg::REG_OPER1: wr_ok = 1'b1;
            default:             wr_ok = 1'b0;  // read-only or unmapped
        endcase
    end

    // write channel handshake
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            awready <= aw_take;
            wready  <= aw_take;
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            bresp <= wr_ok ? sqrt_pkg::RESP_OKAY : sqrt_pkg::RESP_SLVERR;
        end
    end

    // operand registers and start pulses
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            oper0  <= '0;
            oper1  <= '0;
            start0 <= 1'b0;
            start1 <= 1'b0;
        end else begin
            start0 <= wr_hs && (awaddr == sqrt_pkg::REG_CTRL) && wdata[0];
            start1 <= wr_hs && (awaddr == sqrt_pkg::REG_CTRL) && wdata[1];
            if (wr_hs && (awaddr == sqrt_pkg::REG_OPER0)) begin
                oper0 <= wdata[sqrt_pkg::DATA_W-1:0];
            end
            if (wr_hs && (awaddr == sqrt_pkg::REG_OPER1)) begin
                oper1 <= wdata[sqrt_pkg::DATA_W-1:0];
            end
        end
    end

    assign ch0.start   = start0;
    assign ch0.operand = oper0;
    assign ch1.start   = start1;
    assign ch1.operand = oper1;

    // read mux
    always_comb begin
        rd_resp = sqrt_pkg::RESP_OKAY;
        case (araddr)
            sqrt_pkg::REG_OPER0: begin
                rd_data = {{(sqrt_pkg::AXI_DATA_W - sqrt_pkg::DATA_W){1'b0}}, oper0};
            end
            sqrt_pkg::REG_OPER1: begin
                rd_data = {{(sqrt_pkg::AXI_DATA_W - sqrt_pkg::DATA_W){1'b0}}, oper1};
            end
            sqrt_pkg::REG_STATUS:  rd_data = status;
            sqrt_pkg::REG_RESULT0: rd_data = result0;
            sqrt_pkg::REG_RESULT1: rd_data = result1;
            default: begin
                rd_data = '0;                   // CTRL and unmapped
                rd_resp = sqrt_pkg::RESP_SLVERR;
            end
        endcase
    end

    // read channel handshake
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rdata <= rd_data;   // held until the next accepted read
            rresp <= rd_resp;
        end
    end

endmodule

// File: verilog/iterative_sqrt.sv
`timescale 1ns/100ps

module iterative_sqrt (
    input  logic        clk,
    input  logic        rst_n,
    sqrt_chan_if.engine chan
);

    sqrt_pkg::iter_cnt_t            iter_cnt;
    logic [sqrt_pkg::RAD_W-1:0]     x;          // radicand bits not yet consumed
    logic [sqrt_pkg::RAD_W-1:0]     x_next;
    logic [sqrt_pkg::ACC_W-1:0]     acc;
    logic [sqrt_pkg::ACC_W-1:0]     acc_next;
    logic [sqrt_pkg::ACC_W-1:0]     trial;
    logic [sqrt_pkg::ACC_W-1:0]     diff;
    sqrt_pkg::root_t                quot;       // partial root
    sqrt_pkg::root_t                quot_next;
    logic                           busy_q;
    logic                           done_q;
    logic                           accept;
    logic                           last;
    sqrt_pkg::root_t                root_q;
    sqrt_pkg::rem_t                 rem_q;

    assign accept = chan.start && !busy_q;  // start while busy is dropped
    assign last   = busy_q && (iter_cnt == sqrt_pkg::ITER_LAST);

    // one digit step
    always_comb begin
        trial = {{(sqrt_pkg::ACC_W - sqrt_pkg::DATA_W - 2){1'b0}}, quot, 2'b01};
        diff  = acc - trial;
        if (!diff[sqrt_pkg::ACC_W-1]) begin
            {acc_next, x_next} = {diff[sqrt_pkg::RAD_W-1:0], x, 2'b00};
            quot_next = {quot[sqrt_pkg::DATA_W-2:0], 1'b1};
        end else begin
            {acc_next, x_next} = {acc[sqrt_pkg::RAD_W-1:0], x, 2'b00};  // trial too big
            quot_next = {quot[sqrt_pkg::DATA_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            iter_cnt <= '0;
        end else begin
            done_q <= 1'b0;
            if (accept) begin
                busy_q   <= 1'b1;
                iter_cnt <= '0;
            end else if (last) begin
                busy_q   <= 1'b0;
                done_q   <= 1'b1;
                iter_cnt <= '0;
            end else if (busy_q) begin
                iter_cnt <= iter_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            quot <= '0;
            // pre-shift by FRAC_W so the root keeps the fraction bits
            {acc, x} <= {{sqrt_pkg::RAD_W{1'b0}}, chan.operand,
                         {sqrt_pkg::FRAC_W{1'b0}}, 2'b00};
        end else if (last) begin
            root_q <= quot_next;
            rem_q  <= acc_next[sqrt_pkg::DATA_W+1:2];  // drop the trailing shift
        end else if (busy_q) begin
            acc  <= acc_next;
            x    <= x_next;
            quot <= quot_next;
        end
    end

    assign chan.busy      = busy_q;
    assign chan.done      = done_q;
    assign chan.root      = root_q;
    assign chan.remainder = rem_q;

endmodule

// File: verilog/sqrt_result_merge.sv
`timescale 1ns/100ps

module sqrt_result_merge (
    input  logic                 clk,
    input  logic                 rst_n,
    sqrt_chan_if.collect         ch0,
    sqrt_chan_if.collect         ch1,
    output sqrt_pkg::axil_data_t status,
    output sqrt_pkg::axil_data_t result0,
    output sqrt_pkg::axil_data_t result1,
    output logic                 irq
);

    logic done0_q;
    logic done1_q;

    // sticky done flags, a new start wins over a finishing result
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done0_q <= 1'b0;
            done1_q <= 1'b0;
        end else begin
            if (ch0.start) begin    // flag is already clear while busy
                done0_q <= 1'b0;
            end else if (ch0.done) begin
                done0_q <= 1'b1;
            end
            if (ch1.start) begin
                done1_q <= 1'b0;
            end else if (ch1.done) begin
                done1_q <= 1'b1;
            end
        end
    end

    // result words, remainder high and root low
    always_ff @(posedge clk) begin
        if (ch0.done) begin
            result0 <= {ch0.remainder, ch0.root};
        end
        if (ch1.done) begin
            result1 <= {ch1.remainder, ch1.root};
        end
    end

    assign status = {{(sqrt_pkg::AXI_DATA_W - 4){1'b0}},
                     done1_q, done0_q, ch1.busy, ch0.busy};

    assign irq = done0_q || done1_q;

endmodule

// File: verilog/sqrt_accel_top.sv
`timescale 1ns/100ps

module sqrt_accel_top (
    input  logic                 clk,
    input  logic                 rst_n,

    input  sqrt_pkg::axil_addr_t awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  sqrt_pkg::axil_data_t wdata,
    input  logic                 wvalid,
    output logic                 wready,
    output sqrt_pkg::axil_resp_t bresp,
    output logic                 bvalid,
    input  logic                 bready,

    input  sqrt_pkg::axil_addr_t araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output sqrt_pkg::axil_data_t rdata,
    output sqrt_pkg::axil_resp_t rresp,
    output logic                 rvalid,
    input  logic                 rready,

    output logic                 irq
);

    sqrt_pkg::axil_data_t status;
    sqrt_pkg::axil_data_t result0;
    sqrt_pkg::axil_data_t result1;

    sqrt_chan_if ch0_if ();
    sqrt_chan_if ch1_if ();

    axil_sqrt_regs i_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .status  (status),
        .result0 (result0),
        .result1 (result1),
        .ch0     (ch0_if),
        .ch1     (ch1_if)
    );

    iterative_sqrt i_sqrt0 (
        .clk   (clk),
        .rst_n (rst_n),
        .chan  (ch0_if)
    );

    iterative_sqrt i_sqrt1 (
        .clk   (clk),
        .rst_n (rst_n),
        .chan  (ch1_if)
    );

    sqrt_result_merge i_merge (
        .clk     (clk),
        .rst_n   (rst_n),
        .ch0     (ch0_if),
        .ch1     (ch1_if),
        .status  (status),
        .result0 (result0),
        .result1 (result1),
        .irq     (irq)
    );

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD = 10;  // ns, 20 ns clock
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: test/sqrt_accel_checker.sv
`timescale 1ns/100ps

module sqrt_accel_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  sqrt_pkg::axil_addr_t awaddr,
    input  logic                 awvalid,
    input  logic                 awready,
    input  sqrt_pkg::axil_data_t wdata,
    input  logic                 wvalid,
    input  logic                 wready,
    input  sqrt_pkg::axil_resp_t bresp,
    input  logic                 bvalid,
    input  logic                 bready,
    input  sqrt_pkg::axil_addr_t araddr,
    input  logic                 arvalid,
    input  logic                 arready,
    input  sqrt_pkg::axil_data_t rdata,
    input  sqrt_pkg::axil_resp_t rresp,
    input  logic                 rvalid,
    input  logic                 rready,
    input  logic                 irq,
    output int                   error_count
);

    sqrt_pkg::operand_t   oper [2];
    sqrt_pkg::axil_data_t pend_res [2];  // result of the running operation
    sqrt_pkg::axil_data_t result [2];
    int                   steps [2];
    logic [1:0]           start_q;
    logic [1:0]           busy;
    logic [1:0]           done_p;
    logic [1:0]           flag;
    logic [1:0]           accept;
    logic                 held;
    sqrt_pkg::axil_data_t held_data;
    sqrt_pkg::axil_data_t exp_rdata;
    sqrt_pkg::axil_resp_t exp_rresp;
    sqrt_pkg::axil_resp_t exp_bresp;

    // root = floor(sqrt(op * 2^FRAC_W)), remainder = op * 2^FRAC_W - root^2
    function automatic sqrt_pkg::axil_data_t expected_result(input sqrt_pkg::operand_t op);
        int scaled;
        int root;
        scaled = int'(op) << sqrt_pkg::FRAC_W;
        root = 0;
        while ((root + 1) * (root + 1) <= scaled) begin
            root++;
        end
        return {sqrt_pkg::rem_t'(scaled - root * root), sqrt_pkg::root_t'(root)};
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    initial error_count = 0;

    // sampled between edges, so every value is the one the next edge sees
    always @(negedge clk) begin
        if (!rst_n) begin
            oper[0] = '0;
            oper[1] = '0;
            start_q = '0;
            busy    = '0;
            done_p  = '0;
            flag    = '0;
            held    = 1'b0;
        end else begin
            compare("irq", irq, flag[0] || flag[1]);
            if (held && (!rvalid || rdata !== held_data)) begin
                error_count++;
                $display("read response changed while rready was low, at %0t", $time);
            end
            held      = rvalid && !rready;
            held_data = rdata;
            if (rvalid && rready) begin
                compare("rdata", rdata, exp_rdata);
                compare("rresp", rresp, exp_rresp);
            end
            if (bvalid && bready) begin
                compare("bresp", bresp, exp_bresp);
            end
            if (arvalid && arready) begin
                exp_rresp = sqrt_pkg::RESP_OKAY;
                case (araddr)
                    sqrt_pkg::REG_OPER0:   exp_rdata = oper[0];
                    sqrt_pkg::REG_OPER1:   exp_rdata = oper[1];
                    sqrt_pkg::REG_STATUS:  exp_rdata = {flag, busy};
                    sqrt_pkg::REG_RESULT0: exp_rdata = result[0];
                    sqrt_pkg::REG_RESULT1: exp_rdata = result[1];
                    default: begin
                        exp_rdata = '0;
                        exp_rresp = sqrt_pkg::RESP_SLVERR;
                    end
                endcase
            end
            for (int c = 0; c < 2; c++) begin
                accept[c] = start_q[c] && !busy[c];  // start while busy is dropped
                if (done_p[c]) begin
                    result[c] = pend_res[c];
                end
                flag[c]   = accept[c] ? 1'b0 : (done_p[c] ? 1'b1 : flag[c]);
                done_p[c] = 1'b0;
                if (accept[c]) begin
                    busy[c]     = 1'b1;
                    steps[c]    = sqrt_pkg::ITERS;
                    pend_res[c] = expected_result(oper[c]);
                end else if (busy[c]) begin
                    steps[c]--;
                    if (steps[c] == 0) begin
                        busy[c]   = 1'b0;
                        done_p[c] = 1'b1;
                    end
                end
            end
            start_q = 2'b00;
            if (awvalid && awready && wvalid && wready) begin
                exp_bresp = sqrt_pkg::RESP_SLVERR;
                if (awaddr == sqrt_pkg::REG_CTRL) begin
                    start_q   = wdata[1:0];
                    exp_bresp = sqrt_pkg::RESP_OKAY;
                end
                if (awaddr == sqrt_pkg::REG_OPER0 || awaddr == sqrt_pkg::REG_OPER1) begin
                    oper[awaddr == sqrt_pkg::REG_OPER1] = wdata[sqrt_pkg::DATA_W-1:0];
                    exp_bresp = sqrt_pkg::RESP_OKAY;
                end
            end
        end
    end

endmodule

// File: test/sqrt_accel_tb.sv
`timescale 1ns/100ps

module sqrt_accel_tb;

    localparam int NUM_ENTRIES     = 12;
    localparam int WATCHDOG_CYCLES = NUM_ENTRIES * 60 + 200;

    logic                 clk;
    logic                 rst_n;
    sqrt_pkg::axil_addr_t awaddr;
    sqrt_pkg::axil_addr_t araddr;
    sqrt_pkg::axil_data_t wdata;
    sqrt_pkg::axil_data_t rdata;
    sqrt_pkg::axil_resp_t bresp;
    sqrt_pkg::axil_resp_t rresp;
    logic                 awvalid, awready, wvalid, wready, bvalid, bready;
    logic                 arvalid, arready, rvalid, rready;
    logic                 irq;
    int                   errors;
    int                   chk_errors;

    logic                 tbl_chan [NUM_ENTRIES];
    sqrt_pkg::operand_t   tbl_oper [NUM_ENTRIES];
    sqrt_pkg::root_t      tbl_root [NUM_ENTRIES];
    sqrt_pkg::rem_t       tbl_rem  [NUM_ENTRIES];

    tb_clock_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

    sqrt_accel_top i_dut (.*);

    sqrt_accel_checker i_chk (.*, .error_count(chk_errors));

    function automatic sqrt_pkg::root_t floor_sqrt(input sqrt_pkg::operand_t op);
        int v;
        int r;
        v = int'(op) << sqrt_pkg::FRAC_W;
        r = 0;
        while ((r + 1) * (r + 1) <= v) begin
            r++;
        end
        return sqrt_pkg::root_t'(r);
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic write_reg(input sqrt_pkg::axil_addr_t addr, input sqrt_pkg::axil_data_t data,
                             output sqrt_pkg::axil_resp_t resp);
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(negedge clk); while (!(awready && wready));
        @(posedge clk);          // address and data taken here
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(negedge clk); while (!bvalid);
        resp = bresp;
        @(posedge clk);
    endtask

    // hold keeps rready low for that many cycles once rvalid is up
    task automatic read_reg(input sqrt_pkg::axil_addr_t addr, input int hold,
                            output sqrt_pkg::axil_data_t data, output sqrt_pkg::axil_resp_t resp);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= (hold == 0);
        do @(negedge clk); while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        do @(negedge clk); while (!rvalid);
        if (hold > 0) begin
            repeat (hold) @(posedge clk);
            rready <= 1'b1;
            @(negedge clk);
        end
        data = rdata;
        resp = rresp;
        @(posedge clk);
    endtask

    task automatic wait_done(input int chan);
        sqrt_pkg::axil_data_t d;
        sqrt_pkg::axil_resp_t r;
        do read_reg(sqrt_pkg::REG_STATUS, 0, d, r); while (!d[2 + chan]);
    endtask

    task automatic run_entry(input int i);
        sqrt_pkg::axil_data_t d;
        sqrt_pkg::axil_resp_t r;
        int                   ch;
        ch = tbl_chan[i];
        write_reg(ch ? sqrt_pkg::REG_OPER1 : sqrt_pkg::REG_OPER0, tbl_oper[i], r);
        write_reg(sqrt_pkg::REG_CTRL, 1 << ch, r);
        read_reg(sqrt_pkg::REG_STATUS, 0, d, r);
        check_equal("STATUS busy", d[ch], 1'b1);
        check_equal("STATUS done", d[2 + ch], 1'b0);  // cleared by the new start
        wait_done(ch);
        check_equal("irq", irq, 1'b1);
        read_reg(ch ? sqrt_pkg::REG_RESULT1 : sqrt_pkg::REG_RESULT0, 0, d, r);
        check_equal("root", d[15:0], tbl_root[i]);
        check_equal("remainder", d[31:16], tbl_rem[i]);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, tests still running after %0d clock cycles", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin
        sqrt_pkg::axil_data_t d;
        sqrt_pkg::axil_resp_t r;
        int unsigned          seed;
        errors  = 0;
        awaddr  = '0;
        wdata   = '0;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b1;
        seed = $urandom(32'hb1c6f44d);
        tbl_oper[0] = 16'h0000;
        tbl_oper[1] = 16'h0100;  // 1.0
        tbl_oper[2] = 16'hFFFF;
        tbl_oper[3] = 16'h0200;  // 2.0
        tbl_oper[4] = 16'h0001;
        tbl_oper[5] = 16'h0400;  // 4.0
        for (int i = 6; i < NUM_ENTRIES; i++) begin
            tbl_oper[i] = sqrt_pkg::operand_t'($urandom);
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            tbl_chan[i] = i[0];
            tbl_root[i] = floor_sqrt(tbl_oper[i]);
            tbl_rem[i]  = sqrt_pkg::rem_t'((int'(tbl_oper[i]) << sqrt_pkg::FRAC_W)
                                           - int'(tbl_root[i]) * int'(tbl_root[i]));
        end

        wait (rst_n === 1'b1);
        @(posedge clk);
        check_equal("irq after reset", irq, 1'b0);
        read_reg(sqrt_pkg::REG_STATUS, 0, d, r);
        check_equal("STATUS after reset", d, '0);

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(i);
        end

        // both channels from one CTRL write
        write_reg(sqrt_pkg::REG_OPER0, tbl_oper[2], r);
        write_reg(sqrt_pkg::REG_OPER1, tbl_oper[3], r);
        write_reg(sqrt_pkg::REG_CTRL, 32'h3, r);
        wait_done(0);
        wait_done(1);
        read_reg(sqrt_pkg::REG_RESULT0, 0, d, r);
        check_equal("RESULT0 parallel", d, {tbl_rem[2], tbl_root[2]});
        read_reg(sqrt_pkg::REG_RESULT1, 0, d, r);
        check_equal("RESULT1 parallel", d, {tbl_rem[3], tbl_root[3]});

        // second start lands while channel 0 is busy
        write_reg(sqrt_pkg::REG_OPER0, tbl_oper[4], r);
        write_reg(sqrt_pkg::REG_CTRL, 32'h1, r);
        write_reg(sqrt_pkg::REG_OPER0, tbl_oper[5], r);
        write_reg(sqrt_pkg::REG_CTRL, 32'h1, r);
        wait_done(0);
        read_reg(sqrt_pkg::REG_RESULT0, 0, d, r);
        check_equal("RESULT0 after busy start", d, {tbl_rem[4], tbl_root[4]});

        read_reg(5'h18, 0, d, r);
        check_equal("rresp unmapped", r, sqrt_pkg::RESP_SLVERR);
        write_reg(sqrt_pkg::REG_STATUS, 32'hF, r);
        check_equal("bresp STATUS write", r, sqrt_pkg::RESP_SLVERR);
        read_reg(sqrt_pkg::REG_OPER0, 0, d, r);
        check_equal("OPER0 unchanged", d, tbl_oper[5]);

        read_reg(sqrt_pkg::REG_RESULT0, 5, d, r);  // checker watches the stall
        check_equal("RESULT0 after stall", d, {tbl_rem[4], tbl_root[4]});

        $display("errors: %0d in testbench checks, %0d in checker", errors, chk_errors);
        if (errors + chk_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
verilog/sqrt_pkg.sv
verilog/sqrt_chan_if.sv
verilog/axil_sqrt_regs.sv
verilog/iterative_sqrt.sv
verilog/sqrt_result_merge.sv
verilog/sqrt_accel_top.sv
test/tb_clock_gen.sv
test/sqrt_accel_checker.sv
test/sqrt_accel_tb.sv
